// File: Makefile
TOP := spi_apb_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" sim.log; then \
	  echo "Run failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Widths that carry a meaning on the buses
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  // Register offset on the internal bus
  typedef logic [4:0]  reg_addr_t;

  // APB request, held by the master from setup until pready
  typedef struct packed {
    addr_t      paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    word_t      pwdata;
    strb_t      pstrb;
    logic [2:0] pprot;
  } apb_req_t;

  // APB response, valid only in the completion cycle
  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  // Internal register bus, stb held until ack
  typedef struct packed {
    reg_addr_t adr;
    word_t     dat;
    strb_t     sel;
    logic      we;
    logic      stb;
  } reg_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    word_t dat;
  } reg_rsp_t;

  // Address windows, bounds inclusive
  localparam addr_t FLASH_BASE = 32'h3000_0000;
  localparam addr_t FLASH_LAST = 32'h3FFF_FFFF;
  localparam addr_t REGS_BASE  = 32'h1000_1000;
  localparam addr_t REGS_LAST  = 32'h1000_1FFF;

endpackage

`default_nettype wire

// File: common/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Register offsets on the internal bus
  localparam logic [4:0] REG_RX0_TX0 = 5'h00;
  localparam logic [4:0] REG_RX1_TX1 = 5'h04;
  localparam logic [4:0] REG_CTRL    = 5'h10;
  localparam logic [4:0] REG_DIVIDER = 5'h14;
  localparam logic [4:0] REG_SS      = 5'h18;

  // Control register fields
  // Character length lives in bits 6..0, zero means 64
  localparam int CTRL_LEN_MSB = 6;
  localparam int CTRL_GO_BIT  = 8;
  localparam int CTRL_IE_BIT  = 12;

  // Slave select count
  localparam int SPI_SS_NUM = 8;

  // SPI data types
  typedef logic [SPI_SS_NUM-1:0] ss_t;
  typedef logic [63:0]           shift_t;
  typedef logic [6:0]            char_len_t;
  typedef logic [15:0]           divider_t;

  // Flash read command, address follows in 24 bits
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

  // Values programmed for an XIP read
  localparam divider_t  XIP_DIVIDER  = 16'd1;
  localparam char_len_t XIP_CHAR_LEN = 7'd64;

  // Select register value for flash on ss[0]
  localparam ss_t XIP_SS_SEL = 8'h01;

endpackage

`default_nettype wire

// File: flist.f
common/bus_pkg.sv
common/spi_pkg.sv
spi_master/spi_master_regs.sv
spi_master/spi_shift_engine.sv
verilog/xip_sequencer.sv
verilog/spi_apb_top.sv
tests/spi_flash_model.sv
tests/spi_apb_sva.sv
tests/spi_apb_tb.sv

// File: spi_master/spi_master_regs.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master_regs (
  input  wire                clock,
  input  wire                reset,
  input  bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t  reg_rsp_o,
  output logic               start_o,
  output spi_pkg::shift_t    tx_data_o,
  output spi_pkg::char_len_t char_len_o,
  output spi_pkg::divider_t  divider_o,
  input  wire                busy_i,
  input  wire                done_i,
  input  spi_pkg::shift_t    rx_data_i,
  output spi_pkg::ss_t       spi_ss_o,
  output logic               spi_irq_o
);

  // Control state
  logic               ack_q;
  logic               err_q;
  logic               start_q;
  logic               irq_q;
  logic               ie_q;
  spi_pkg::char_len_t len_q;
  spi_pkg::divider_t  div_q;
  spi_pkg::ss_t       ss_q;

  // Payload
  bus_pkg::word_t     tx0_q;
  bus_pkg::word_t     tx1_q;
  bus_pkg::word_t     rdat_q;

  logic               access;
  logic               valid;
  bus_pkg::word_t     ctrl_word;
  bus_pkg::word_t     rd_word;
  bus_pkg::word_t     ctrl_new;
  bus_pkg::word_t     div_new;
  bus_pkg::word_t     ss_new;

  // Byte lane merge of a write into an old value
  function automatic bus_pkg::word_t merge_bytes(bus_pkg::word_t old_w,
                                                 bus_pkg::word_t new_w,
                                                 bus_pkg::strb_t sel);
    bus_pkg::word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // One access per stb, ack low for a cycle in between
  assign access = reg_req_i.stb & ~ack_q;

  // Go reads back as busy, including the start cycle
  always_comb begin
    ctrl_word = '0;
    ctrl_word[spi_pkg::CTRL_LEN_MSB:0] = len_q;
    ctrl_word[spi_pkg::CTRL_GO_BIT] = busy_i | start_q;
    ctrl_word[spi_pkg::CTRL_IE_BIT] = ie_q;
  end

  assign ctrl_new = merge_bytes(ctrl_word, reg_req_i.dat, reg_req_i.sel);
  assign div_new  = merge_bytes({16'h0, div_q}, reg_req_i.dat, reg_req_i.sel);
  assign ss_new   = merge_bytes({24'h0, ss_q}, reg_req_i.dat, reg_req_i.sel);

  // Address map and read mux
  always_comb begin
    valid   = 1'b1;
    rd_word = '0;
    case (reg_req_i.adr)
      spi_pkg::REG_RX0_TX0: rd_word = rx_data_i[31:0];
      spi_pkg::REG_RX1_TX1: rd_word = rx_data_i[63:32];
      spi_pkg::REG_CTRL:    rd_word = ctrl_word;
      spi_pkg::REG_DIVIDER: rd_word = {16'h0, div_q};
      spi_pkg::REG_SS:      rd_word = {{(32-spi_pkg::SPI_SS_NUM){1'b0}}, ss_q};
      default:              valid = 1'b0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      start_q <= 1'b0;
      irq_q   <= 1'b0;
      ie_q    <= 1'b0;
      len_q   <= '0;
      div_q   <= '0;
      ss_q    <= '0;
    end else begin
      ack_q   <= access;
      err_q   <= access & ~valid;
      start_q <= 1'b0;
      if (access && reg_req_i.we) begin
        case (reg_req_i.adr)
          spi_pkg::REG_CTRL: begin
            len_q   <= ctrl_new[spi_pkg::CTRL_LEN_MSB:0];
            ie_q    <= ctrl_new[spi_pkg::CTRL_IE_BIT];
            // Start only from idle, pulse lands in the ack cycle
            start_q <= ctrl_new[spi_pkg::CTRL_GO_BIT] & ~busy_i & ~start_q;
          end
          spi_pkg::REG_DIVIDER: begin
            div_q <= div_new[15:0];
          end
          spi_pkg::REG_SS: begin
            ss_q <= ss_new[spi_pkg::SPI_SS_NUM-1:0];
          end
          default: ;
        endcase
      end
      // Done wins over a clearing CTRL access
      if (done_i && ie_q) begin
        irq_q <= 1'b1;
      end else if (access && reg_req_i.adr == spi_pkg::REG_CTRL) begin
        irq_q <= 1'b0;
      end
    end
  end

  // TX halves and registered read data
  always_ff @(posedge clock) begin
    if (access && reg_req_i.we && reg_req_i.adr == spi_pkg::REG_RX0_TX0) begin
      tx0_q <= merge_bytes(tx0_q, reg_req_i.dat, reg_req_i.sel);
    end
    if (access && reg_req_i.we && reg_req_i.adr == spi_pkg::REG_RX1_TX1) begin
      tx1_q <= merge_bytes(tx1_q, reg_req_i.dat, reg_req_i.sel);
    end
    if (access) begin
      rdat_q <= rd_word;
    end
  end

  assign reg_rsp_o.ack = ack_q;
  assign reg_rsp_o.err = err_q;
  assign reg_rsp_o.dat = rdat_q;

  assign start_o    = start_q;
  assign tx_data_o  = {tx1_q, tx0_q};
  assign char_len_o = len_q;
  assign divider_o  = div_q;
  // Selects are active low on the pins
  assign spi_ss_o   = ~ss_q;
  assign spi_irq_o  = irq_q;

endmodule

`default_nettype wire

// File: spi_master/spi_shift_engine.sv
`timescale 1ns/10ps
`default_nettype none

module spi_shift_engine (
  input  wire                clock,
  input  wire                reset,
  input  wire                start_i,
  input  spi_pkg::shift_t    tx_data_i,
  input  spi_pkg::char_len_t char_len_i,
  input  spi_pkg::divider_t  divider_i,
  output logic               busy_o,
  output logic               done_o,
  output spi_pkg::shift_t    rx_data_o,
  output logic               spi_sck_o,
  input  wire                spi_miso_i,
  output logic               spi_mosi_o
);

  // Control state
  logic              busy_q;
  logic              done_q;
  logic              sck_q;
  logic              mosi_q;
  spi_pkg::divider_t clk_cnt_q;
  logic [6:0]        bit_cnt_q;

  // Transfer payload, latched at start
  spi_pkg::shift_t   shreg_q;
  spi_pkg::divider_t div_q;
  logic [5:0]        top_q;

  logic [5:0]        start_top;
  logic              half_end;
  logic              rise;

  // Index of the first bit out, zero length means 64
  assign start_top = (char_len_i == '0 || char_len_i > 7'd64) ? 6'd63
                                                               : 6'(char_len_i - 7'd1);

  // End of an SCK half period
  assign half_end = busy_q && (clk_cnt_q == div_q);
  // SCK about to go high
  assign rise     = half_end && !sck_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      sck_q     <= 1'b0;
      mosi_q    <= 1'b0;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (start_i) begin
          busy_q    <= 1'b1;
          sck_q     <= 1'b0;
          clk_cnt_q <= '0;
          bit_cnt_q <= 7'(start_top) + 7'd1;
          // First bit valid before the first rising edge
          mosi_q    <= tx_data_i[start_top];
        end
      end else if (half_end) begin
        clk_cnt_q <= '0;
        sck_q     <= ~sck_q;
        if (!sck_q) begin
          bit_cnt_q <= bit_cnt_q - 7'd1;
        end else if (bit_cnt_q == '0) begin
          // Last falling edge closes the transfer
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          // Next bit out, already shifted into the top position
          mosi_q <= shreg_q[top_q];
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!busy_q && start_i) begin
      shreg_q <= tx_data_i;
      div_q   <= divider_i;
      top_q   <= start_top;
    end else if (rise) begin
      // Sample MISO into the bottom bit
      shreg_q <= {shreg_q[62:0], spi_miso_i};
    end
  end

  // Received bits right-aligned, stale tx bits masked off
  assign rx_data_o  = shreg_q & (64'hFFFF_FFFF_FFFF_FFFF >> (6'd63 - top_q));

  assign busy_o     = busy_q;
  assign done_o     = done_q;
  assign spi_sck_o  = sck_q;
  assign spi_mosi_o = mosi_q;

endmodule

`default_nettype wire

// File: tests/spi_apb_sva.sv
`timescale 1ns/10ps
`default_nettype none

module spi_apb_sva (
  input wire               clock,
  input wire               reset,
  input bus_pkg::apb_req_t apb_req_i,
  input bus_pkg::apb_rsp_t apb_rsp_i,
  input spi_pkg::ss_t      spi_ss_i,
  input wire               spi_sck_i
);

  // Ready only inside an access phase
  a_ready_in_access: assert property (@(posedge clock) disable iff (reset)
    apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
    else $error("pready high outside an APB access phase");

  // Error only in the completion cycle
  a_err_with_ready: assert property (@(posedge clock) disable iff (reset)
    apb_rsp_i.pslverr |-> apb_rsp_i.pready)
    else $error("pslverr high without pready");

  // Active low selects, one at most
  a_one_select: assert property (@(posedge clock) disable iff (reset)
    $onehot0(~spi_ss_i))
    else $error("more than one slave select active");

  // No clock edges toward deselected slaves
  a_sck_idle: assert property (@(posedge clock) disable iff (reset)
    (&spi_ss_i) |-> $stable(spi_sck_i))
    else $error("SCK toggled with all selects released");

endmodule

bind spi_apb_top spi_apb_sva u_spi_apb_sva (
  .clock     (clock),
  .reset     (reset),
  .apb_req_i (apb_req_i),
  .apb_rsp_i (apb_rsp_o),
  .spi_ss_i  (spi_ss_o),
  .spi_sck_i (spi_sck_o)
);

`default_nettype wire

// File: tests/spi_apb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module spi_apb_tb;

  // Bounds in clock cycles and in CTRL polls
  localparam int READY_LIMIT = 2000;
  localparam int POLL_LIMIT  = 1000;

  logic              clock;
  logic              reset;
  bus_pkg::apb_req_t apb_req;
  bus_pkg::apb_rsp_t apb_rsp;
  logic              spi_sck;
  spi_pkg::ss_t      spi_ss;
  logic              spi_mosi;
  logic              spi_miso;
  logic              spi_irq;

  int   seed;
  int   checks;
  int   errors;
  int   test_base;
  logic timed_out;

  spi_apb_top dut (
    .clock      (clock),
    .reset      (reset),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash on select 0
  spi_flash_model u_flash (
    .sck_i  (spi_sck),
    .ss_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Ends the run once a wait has timed out
  initial begin
    wait (timed_out === 1'b1);
    $display("Simulation FAILED");
    $finish;
  end

  // Reference content, one byte per flash address
  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
  endfunction

  // First byte lands in the top lane
  function automatic bus_pkg::word_t flash_word(input logic [23:0] a);
    return {flash_byte(a), flash_byte(a + 24'd1), flash_byte(a + 24'd2),
            flash_byte(a + 24'd3)};
  endfunction

  function automatic bus_pkg::addr_t reg_addr(input logic [4:0] off);
    return bus_pkg::REGS_BASE | {27'h0, off};
  endfunction

  task automatic check_word(input string name, input bus_pkg::word_t got,
                            input bus_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One bit flags, pslverr and the interrupt
  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_ss(input string name, input spi_pkg::ss_t got,
                          input spi_pkg::ss_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Flags a stuck wait for the watchdog
  task automatic abort_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timed_out = 1'b1;
    @(negedge clock);
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic apb_access(input logic write, input bus_pkg::addr_t addr,
                            input bus_pkg::word_t wdata,
                            output bus_pkg::word_t rdata, output logic err);
    int cycles;
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = '1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clock);
    apb_req.penable = 1'b1;
    cycles = 0;
    @(negedge clock);
    while (!apb_rsp.pready && cycles < READY_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!apb_rsp.pready) begin
      abort_timeout("APB access never got pready");
    end else begin
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      // Transfer closes on the next rising edge
      @(negedge clock);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic apb_write(input bus_pkg::addr_t addr, input bus_pkg::word_t data,
                           output logic err);
    bus_pkg::word_t ignored;
    apb_access(1'b1, addr, data, ignored, err);
  endtask

  task automatic apb_read(input bus_pkg::addr_t addr, output bus_pkg::word_t data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // Flash read header in TX1, 64 bit transfer on ss[0]
  task automatic start_flash_read(input logic [23:0] addr, input logic [1:0] div,
                                  input logic ie);
    logic err;
    apb_write(reg_addr(spi_pkg::REG_RX1_TX1), {spi_pkg::FLASH_READ_CMD, addr}, err);
    apb_write(reg_addr(spi_pkg::REG_DIVIDER), {30'h0, div}, err);
    apb_write(reg_addr(spi_pkg::REG_SS), 32'h1, err);
    apb_write(reg_addr(spi_pkg::REG_CTRL), {19'h0, ie, 3'h0, 1'b1, 1'b0, 7'd64}, err);
  endtask

  task automatic test_readback();
    logic [31:0]    rnd;
    bus_pkg::word_t rdata;
    bus_pkg::word_t ctrl;
    spi_pkg::ss_t   ss;
    logic           err;
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      apb_write(reg_addr(spi_pkg::REG_DIVIDER), {16'h0, rnd[15:0]}, err);
      apb_read(reg_addr(spi_pkg::REG_DIVIDER), rdata, err);
      check_word("DIVIDER", rdata, {16'h0, rnd[15:0]});
      // None or a single select
      ss = rnd[19] ? 8'h00 : 8'h01 << rnd[18:16];
      apb_write(reg_addr(spi_pkg::REG_SS), {24'h0, ss}, err);
      apb_read(reg_addr(spi_pkg::REG_SS), rdata, err);
      check_word("SS", rdata, {24'h0, ss});
      check_ss("spi_ss_o", spi_ss, ~ss);
      // IE and length, go left clear
      ctrl = {19'h0, rnd[20], 5'h0, rnd[27:21]};
      apb_write(reg_addr(spi_pkg::REG_CTRL), ctrl, err);
      apb_read(reg_addr(spi_pkg::REG_CTRL), rdata, err);
      check_word("CTRL", rdata, ctrl);
      check_err("pslverr", err, 1'b0);
    end
    apb_write(reg_addr(spi_pkg::REG_SS), 32'h0, err);
  endtask

  task automatic test_manual();
    logic [31:0]    rnd;
    bus_pkg::word_t rdata;
    logic           err;
    int             polls;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      start_flash_read(rnd[23:0], rnd[25:24], 1'b0);
      polls = 0;
      do begin
        apb_read(reg_addr(spi_pkg::REG_CTRL), rdata, err);
        polls++;
      end while (rdata[spi_pkg::CTRL_GO_BIT] && polls < POLL_LIMIT);
      if (rdata[spi_pkg::CTRL_GO_BIT]) begin
        abort_timeout("go bit never cleared after a manual transfer");
      end else begin
        apb_read(reg_addr(spi_pkg::REG_RX0_TX0), rdata, err);
        check_word("RX0", rdata, flash_word(rnd[23:0]));
        check_err("pslverr", err, 1'b0);
        apb_write(reg_addr(spi_pkg::REG_SS), 32'h0, err);
        check_ss("spi_ss_o", spi_ss, 8'hFF);
      end
    end
  endtask

  task automatic test_xip();
    logic [31:0]    rnd;
    bus_pkg::addr_t addr;
    bus_pkg::word_t rdata;
    logic           err;
    for (int i = 0; i < 40; i++) begin
      rnd  = $random(seed);
      addr = bus_pkg::FLASH_BASE | {4'h0, rnd[27:0]};
      apb_read(addr, rdata, err);
      // Flash sees only the low 24 address bits
      check_word("prdata", rdata, flash_word(addr[23:0]));
      check_err("pslverr", err, 1'b0);
    end
    check_ss("spi_ss_o", spi_ss, 8'hFF);
  endtask

  task automatic test_errors();
    bus_pkg::word_t rdata;
    logic           err;
    apb_write(bus_pkg::FLASH_BASE | 32'h0012_3450, 32'hDEAD_BEEF, err);
    check_err("pslverr", err, 1'b1);
    apb_read(32'h2000_0000, rdata, err);
    check_err("pslverr", err, 1'b1);
    apb_write(32'h0000_0100, 32'h1, err);
    check_err("pslverr", err, 1'b1);
    // Holes in the register map
    apb_read(reg_addr(5'h08), rdata, err);
    check_err("pslverr", err, 1'b1);
    apb_write(reg_addr(5'h1C), 32'h5, err);
    check_err("pslverr", err, 1'b1);
    apb_read(bus_pkg::REGS_BASE | 32'h100, rdata, err);
    check_err("pslverr", err, 1'b1);
  endtask

  task automatic test_irq();
    logic [31:0]    rnd;
    bus_pkg::word_t rdata;
    logic           err;
    logic           sck_prev;
    int             cycles;
    int             falls;
    rnd = $random(seed);
    start_flash_read(rnd[23:0], 2'd0, 1'b1);
    cycles   = 0;
    falls    = 0;
    sck_prev = spi_sck;
    // Completion seen on SCK since a CTRL poll clears the interrupt
    while (falls < 64 && cycles < READY_LIMIT) begin
      @(negedge clock);
      if (sck_prev && !spi_sck) begin
        falls++;
      end
      sck_prev = spi_sck;
      cycles++;
    end
    if (falls < 64) begin
      abort_timeout("SCK stopped before all 64 bits of a manual transfer");
    end else begin
      // Last falling edge ends the transfer
      cycles = 0;
      while (!spi_irq && cycles < 4) begin
        @(negedge clock);
        cycles++;
      end
      check_err("spi_irq_o", spi_irq, 1'b1);
      apb_read(reg_addr(spi_pkg::REG_CTRL), rdata, err);
      check_word("CTRL", rdata, 32'h0000_1040);
      check_err("spi_irq_o", spi_irq, 1'b0);
      apb_write(reg_addr(spi_pkg::REG_SS), 32'h0, err);
      apb_write(reg_addr(spi_pkg::REG_CTRL), 32'h0, err);
    end
  endtask

  initial begin
    seed      = 32'hd315db71;
    checks    = 0;
    errors    = 0;
    test_base = 0;
    timed_out = 1'b0;
    apb_req   = '0;
    reset     = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    check_ss("spi_ss_o", spi_ss, 8'hFF);
    check_err("spi_irq_o", spi_irq, 1'b0);
    check_err("spi_sck_o", spi_sck, 1'b0);
    check_err("pready", apb_rsp.pready, 1'b0);
    check_err("pslverr", apb_rsp.pslverr, 1'b0);
    @(negedge clock);
    test_readback();
    report_test("register readback");
    test_manual();
    report_test("manual transfer");
    test_xip();
    report_test("XIP reads");
    test_errors();
    report_test("error responses");
    test_irq();
    report_test("interrupt");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/spi_flash_model.sv
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model (
  input  wire  sck_i,
  input  wire  ss_n_i,
  input  wire  mosi_i,
  output logic miso_o
);

  // Command byte and 24 bit address, MSB first
  logic [31:0] in_sr;
  // Rising SCK edges since select
  logic [7:0]  bit_cnt;
  logic        out_bit;

  // Position in the read data stream
  logic [7:0]  data_idx;
  logic [7:0]  cur_byte;

  // Stored content is computed from the byte address
  function automatic logic [7:0] byte_at(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
  endfunction

  initial out_bit = 1'b0;

  assign data_idx = bit_cnt - 8'd32;
  assign cur_byte = byte_at(in_sr[23:0] + {19'h0, data_idx[7:3]});

  // Mode 0, MOSI sampled on rising SCK
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt <= 8'd0;
    end else begin
      if (bit_cnt < 8'd32) begin
        in_sr <= {in_sr[30:0], mosi_i};
      end
      bit_cnt <= bit_cnt + 8'd1;
    end
  end

  // Data out after the header, changes on falling SCK
  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      out_bit <= 1'b0;
    end else if (bit_cnt >= 8'd32 && in_sr[31:24] == 8'h03) begin
      out_bit <= cur_byte[3'd7 - data_idx[2:0]];
    end else begin
      out_bit <= 1'b0;
    end
  end

  assign miso_o = out_bit;

endmodule

`default_nettype wire

// File: verilog/spi_apb_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_apb_top (
  input  wire               clock,
  input  wire               reset,
  input  bus_pkg::apb_req_t apb_req_i,
  output bus_pkg::apb_rsp_t apb_rsp_o,
  output logic              spi_sck_o,
  output spi_pkg::ss_t      spi_ss_o,
  output logic              spi_mosi_o,
  input  wire               spi_miso_i,
  output logic              spi_irq_o
);

  // Internal register bus
  bus_pkg::reg_req_t  reg_req;
  bus_pkg::reg_rsp_t  reg_rsp;

  // Side band to the shift engine
  logic               start;
  logic               busy;
  logic               done;
  spi_pkg::shift_t    tx_data;
  spi_pkg::shift_t    rx_data;
  spi_pkg::char_len_t char_len;
  spi_pkg::divider_t  divider;

  xip_sequencer u_xip_sequencer (
    .clock     (clock),
    .reset     (reset),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  spi_master_regs u_spi_master_regs (
    .clock      (clock),
    .reset      (reset),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .start_o    (start),
    .tx_data_o  (tx_data),
    .char_len_o (char_len),
    .divider_o  (divider),
    .busy_i     (busy),
    .done_i     (done),
    .rx_data_i  (rx_data),
    .spi_ss_o   (spi_ss_o),
    .spi_irq_o  (spi_irq_o)
  );

  spi_shift_engine u_spi_shift_engine (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .tx_data_i  (tx_data),
    .char_len_i (char_len),
    .divider_i  (divider),
    .busy_o     (busy),
    .done_o     (done),
    .rx_data_o  (rx_data),
    .spi_sck_o  (spi_sck_o),
    .spi_miso_i (spi_miso_i),
    .spi_mosi_o (spi_mosi_o)
  );

endmodule

`default_nettype wire

// File: verilog/xip_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module xip_sequencer (
  input  wire               clock,
  input  wire               reset,
  input  bus_pkg::apb_req_t apb_req_i,
  output bus_pkg::apb_rsp_t apb_rsp_o,
  output bus_pkg::reg_req_t reg_req_o,
  input  bus_pkg::reg_rsp_t reg_rsp_i
);

  typedef enum logic [3:0] {
    IDLE,
    REG_ACCESS,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_DONE,
    READ_DATA,
    RELEASE_SS,
    RESPOND
  } state_t;

  state_t         state_q;
  state_t         next_step;
  logic           stb_q;
  logic           err_q;
  bus_pkg::word_t rd_data_q;

  logic           access;
  logic           is_flash;
  logic           is_regs;
  logic           step_ack;
  bus_pkg::word_t ctrl_go;

  // APB access phase
  assign access = apb_req_i.psel & apb_req_i.penable;

  // Window decode, register window holds only the low 32 bytes
  assign is_flash = (apb_req_i.paddr >= bus_pkg::FLASH_BASE) &&
                    (apb_req_i.paddr <= bus_pkg::FLASH_LAST);
  assign is_regs  = (apb_req_i.paddr >= bus_pkg::REGS_BASE) &&
                    (apb_req_i.paddr <= bus_pkg::REGS_LAST) &&
                    (apb_req_i.paddr[11:5] == '0);

  // Ack for the step in flight
  assign step_ack = stb_q & reg_rsp_i.ack;

  // Control word that starts a 64 bit transfer
  always_comb begin
    ctrl_go = '0;
    ctrl_go[spi_pkg::CTRL_LEN_MSB:0] = spi_pkg::XIP_CHAR_LEN;
    ctrl_go[spi_pkg::CTRL_GO_BIT] = 1'b1;
  end

  // Step order of a flash read
  always_comb begin
    case (state_q)
      SEND_CMD:    next_step = SET_DIVIDER;
      SET_DIVIDER: next_step = SET_SS;
      SET_SS:      next_step = GO_BUSY;
      GO_BUSY:     next_step = WAIT_DONE;
      WAIT_DONE:   next_step = READ_DATA;
      READ_DATA:   next_step = RELEASE_SS;
      RELEASE_SS:  next_step = RESPOND;
      default:     next_step = IDLE;
    endcase
  end

  // Request fields per state, stb from the step register
  always_comb begin
    reg_req_o     = '0;
    reg_req_o.sel = '1;
    reg_req_o.stb = stb_q;
    case (state_q)
      REG_ACCESS: begin
        reg_req_o.adr = apb_req_i.paddr[4:0];
        reg_req_o.dat = apb_req_i.pwdata;
        reg_req_o.sel = apb_req_i.pstrb;
        reg_req_o.we  = apb_req_i.pwrite;
      end
      SEND_CMD: begin
        // Command and 24 bit address go out first from TX1
        reg_req_o.adr = spi_pkg::REG_RX1_TX1;
        reg_req_o.dat = {spi_pkg::FLASH_READ_CMD, apb_req_i.paddr[23:0]};
        reg_req_o.we  = 1'b1;
      end
      SET_DIVIDER: begin
        reg_req_o.adr = spi_pkg::REG_DIVIDER;
        reg_req_o.dat = {16'h0, spi_pkg::XIP_DIVIDER};
        reg_req_o.we  = 1'b1;
      end
      SET_SS: begin
        reg_req_o.adr = spi_pkg::REG_SS;
        reg_req_o.dat = {{(32-spi_pkg::SPI_SS_NUM){1'b0}}, spi_pkg::XIP_SS_SEL};
        reg_req_o.we  = 1'b1;
      end
      GO_BUSY: begin
        reg_req_o.adr = spi_pkg::REG_CTRL;
        reg_req_o.dat = ctrl_go;
        reg_req_o.we  = 1'b1;
      end
      WAIT_DONE:  reg_req_o.adr = spi_pkg::REG_CTRL;
      READ_DATA:  reg_req_o.adr = spi_pkg::REG_RX0_TX0;
      RELEASE_SS: begin
        // Zero select register releases all pins
        reg_req_o.adr = spi_pkg::REG_SS;
        reg_req_o.we  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
      stb_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (access) begin
            if (is_regs) begin
              state_q <= REG_ACCESS;
              stb_q   <= 1'b1;
            end else if (is_flash && !apb_req_i.pwrite) begin
              state_q <= SEND_CMD;
              stb_q   <= 1'b1;
            end else begin
              // Unmapped or flash write, answer at once
              state_q <= RESPOND;
              err_q   <= 1'b1;
            end
          end
        end
        REG_ACCESS: begin
          if (step_ack) begin
            stb_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        RESPOND: begin
          state_q <= IDLE;
          err_q   <= 1'b0;
        end
        default: begin
          // Bus step, stb idles a cycle between steps
          if (!stb_q) begin
            stb_q <= 1'b1;
          end else if (reg_rsp_i.ack) begin
            stb_q <= 1'b0;
            // Poll repeats while go still reads set
            if (state_q != WAIT_DONE || !reg_rsp_i.dat[spi_pkg::CTRL_GO_BIT]) begin
              state_q <= next_step;
            end
          end
        end
      endcase
    end
  end

  // RX0 word held until the select is released
  always_ff @(posedge clock) begin
    if (state_q == READ_DATA && step_ack) begin
      rd_data_q <= reg_rsp_i.dat;
    end
  end

  // Only the final step completes the APB transfer
  assign apb_rsp_o.pready  = (state_q == RESPOND) ||
                             (state_q == REG_ACCESS && step_ack);
  assign apb_rsp_o.prdata  = (state_q == REG_ACCESS) ? reg_rsp_i.dat : rd_data_q;
  assign apb_rsp_o.pslverr = (state_q == REG_ACCESS) ? (step_ack & reg_rsp_i.err)
                                                     : (state_q == RESPOND) & err_q;

endmodule

`default_nettype wire
